//--- design/bp_config.svh
/*
  Branch front end configuration
  Table index width, PC width and the reset vector
*/

`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

////////////////////
// Table geometry
////////////////////

// PC bits [INDEX_BITS:1] select a BHT/BTB entry
`define BP_INDEX_BITS 3

////////////////////
// Program counter
////////////////////

`define BP_PC_BITS 16     // PC and target width

// First fetch address after reset
`define BP_RESET_PC 16'h0000

`endif

//--- design/bp_state_pkg.sv
/*
  Branch predictor state package
  Two-bit saturating counter type and its helper functions
*/

package bp_state_pkg;

  // Upper bit of the state is the taken prediction
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } counter_t;

  // Taken bit of a counter
  function automatic logic predicts_taken(counter_t state);
    return state[1];
  endfunction

  // Saturating step toward the actual outcome
  function automatic counter_t counter_next(counter_t state, logic taken);
    counter_t next_state;
    case (state)
      strong_not_taken: next_state = taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   next_state = taken ? weak_taken     : strong_not_taken;
      weak_taken:       next_state = taken ? strong_taken   : weak_not_taken;
      strong_taken:     next_state = taken ? strong_taken   : weak_taken;
      default:          next_state = strong_not_taken;      // Unknown state recovers cold
    endcase
    return next_state;
  endfunction

endpackage

//--- design/isa_pkg.sv
/*
  Instruction set package
  Opcodes and the 16-bit instruction word, seen as a branch or as a jump
*/

package isa_pkg;

  ////////////////////
  // Opcodes
  ////////////////////

  // Only branch and jump matter to the front end
  typedef enum logic [3:0] {
    op_nop    = 4'h0,
    op_alu    = 4'h1,
    op_load   = 4'h2,
    op_store  = 4'h3,
    op_branch = 4'hc,     // Conditional, tested against flags
    op_jump   = 4'hd      // Unconditional
  } opcode_t;

  ////////////////////
  // Word layouts
  ////////////////////

  // [15:12] opcode, [11:9] condition mask, [8:0] word offset
  typedef struct packed {
    opcode_t            opcode;
    logic [2:0]         cond;     // ANDed with flags
    logic signed [8:0]  offset;   // In words, relative to pc+2
  } branch_view_t;

  // [15:12] opcode, [11:0] word offset
  typedef struct packed {
    opcode_t            opcode;
    logic signed [11:0] offset;   // In words, relative to pc+2
  } jump_view_t;

  // Same 16 bits, decoded by opcode
  typedef union packed {
    branch_view_t br;
    jump_view_t   jmp;
  } instr_word_u;

endpackage

//--- design/branch_predictor.sv
/*
  Dynamic branch predictor
  Counter table (BHT) and target table (BTB), untagged, indexed by PC bits above bit 0.
  Lookup is combinational, updates come from decode and land at the next edge.
*/

`timescale 1ns/1ps

`include "bp_config.svh"

module branch_predictor (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,            // Freezes both tables when low
  input  logic [15:0]             fetch_pc,          // Lookup address
  input  logic [15:0]             id_pc,             // Update address
  input  bp_state_pkg::counter_t  id_prediction,     // State seen at fetch time
  input  logic                    bht_wen,
  input  logic                    btb_wen,
  input  logic                    update_taken,      // Resolved outcome
  input  logic [15:0]             actual_target,     // Resolved target
  output bp_state_pkg::counter_t  prediction,
  output logic [15:0]             predicted_target
);

  import bp_state_pkg::*;

  localparam int ENTRIES = 1 << `BP_INDEX_BITS;

  counter_t                  bht [ENTRIES];   // Two-bit counters
  logic [`BP_PC_BITS-1:0]    btb [ENTRIES];   // Last taken target per entry

  logic [`BP_INDEX_BITS-1:0] rd_idx;
  logic [`BP_INDEX_BITS-1:0] wr_idx;
  counter_t                  bht_next;

  // Word aligned PCs, so bit 0 is skipped
  assign rd_idx = fetch_pc[`BP_INDEX_BITS:1];
  assign wr_idx = id_pc[`BP_INDEX_BITS:1];

  ////////////////////
  // Lookup
  ////////////////////

  assign prediction       = bht[rd_idx];
  assign predicted_target = btb[rd_idx];

  ////////////////////
  // BHT update
  ////////////////////

  // Step from the state fetch saw, not a fresh read
  assign bht_next = counter_next(id_prediction, update_taken);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        bht[i] <= strong_not_taken;   // Cold start predicts fall through
      end
    end else if (enable && bht_wen) begin
      bht[wr_idx] <= bht_next;
    end
  end

  ////////////////////
  // BTB update
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ENTRIES; i++) begin
        btb[i] <= '0;
      end
    end else if (enable && btb_wen) begin
      btb[wr_idx] <= actual_target;   // Only taken outcomes reach here
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Resolver writes a target only for a taken branch
  btb_wen_taken: assert property (@(posedge clk) disable iff (rst)
    btb_wen |-> update_taken)
    else $error("BTB write on a not-taken outcome");

  // Stalled pipeline must not update the tables
  no_write_stalled: assert property (@(posedge clk) disable iff (rst)
    !enable |-> !(bht_wen || btb_wen))
    else $error("Table write while enable is low");

endmodule

//--- design/fetch_unit.sv
/*
  Fetch stage
  PC register, next-PC select and the IF/ID pipeline register.
  A redirect from decode reloads the PC and squashes the word fetched alongside it.
*/

`timescale 1ns/1ps

`include "bp_config.svh"

module fetch_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    enable,            // Stall when low
  input  logic [15:0]             instr,             // Same cycle answer to pc
  input  bp_state_pkg::counter_t  prediction,
  input  logic [15:0]             predicted_target,
  input  logic                    redirect,          // Mispredict strobe from decode
  input  logic [15:0]             redirect_pc,
  output logic [15:0]             pc,
  output logic                    id_valid,
  output logic [15:0]             id_pc,
  output logic [15:0]             id_instr,
  output logic [15:0]             id_target,         // BTB target seen at fetch
  output bp_state_pkg::counter_t  id_prediction
);

  import bp_state_pkg::*;

  logic [`BP_PC_BITS-1:0] pc_plus2;
  logic [`BP_PC_BITS-1:0] next_pc;

  assign pc_plus2 = pc + `BP_PC_BITS'd2;

  ////////////////////
  // Next PC
  ////////////////////

  // Redirect beats prediction beats sequential
  always_comb begin
    if (redirect) begin
      next_pc = redirect_pc;
    end else if (predicts_taken(prediction)) begin
      next_pc = predicted_target;
    end else begin
      next_pc = pc_plus2;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `BP_RESET_PC;
    end else if (enable) begin
      pc <= next_pc;
    end
  end

  ////////////////////
  // IF/ID register
  ////////////////////

  // Valid bit drops when the current fetch is on the wrong path
  always_ff @(posedge clk) begin
    if (rst) begin
      id_valid <= 1'b0;
    end else if (enable) begin
      id_valid <= !redirect;
    end
  end

  // Fetched word with its PC, prediction and BTB target
  always_ff @(posedge clk) begin
    if (enable) begin
      id_pc         <= pc;
      id_instr      <= instr;
      id_prediction <= prediction;
      id_target     <= predicted_target;   // Compared against the real target in decode
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Redirect and BTB targets keep fetch on word boundaries
  pc_aligned: assert property (@(posedge clk) disable iff (rst)
    !pc[0])
    else $error("PC is not word aligned");

endmodule

//--- design/branch_resolver.sv
/*
  Decode-stage branch resolver
  Decodes the IF/ID word, works out outcome and target, detects a mispredict
  and drives the table writes and the fetch redirect.
*/

`timescale 1ns/1ps

`include "bp_config.svh"

module branch_resolver (
  input  logic                    enable,
  input  logic                    id_valid,
  input  logic [15:0]             id_pc,
  input  logic [15:0]             id_instr,
  input  logic [15:0]             id_target,       // BTB target seen at fetch
  input  bp_state_pkg::counter_t  id_prediction,
  input  logic [2:0]              flags,
  output logic                    resolve_valid,   // One strobe per branch or jump
  output logic                    resolve_taken,
  output logic                    bht_wen,
  output logic                    btb_wen,
  output logic                    update_taken,
  output logic                    redirect,        // Also the mispredict flag
  output logic [15:0]             actual_target,
  output logic [15:0]             redirect_pc
);

  import bp_state_pkg::*;
  import isa_pkg::*;

  instr_word_u            word;
  logic                   is_branch;
  logic                   is_jump;
  logic                   taken;
  logic                   pred_taken;
  logic                   wrong_target;
  logic [`BP_PC_BITS-1:0] seq_pc;
  logic [`BP_PC_BITS-1:0] br_disp;
  logic [`BP_PC_BITS-1:0] jmp_disp;

  assign word = id_instr;

  ////////////////////
  // Decode
  ////////////////////

  // Opcode sits in the same bits for both views
  assign is_branch = (word.br.opcode == op_branch);
  assign is_jump   = (word.jmp.opcode == op_jump);

  // Any enabled flag in the mask takes the branch
  assign taken = is_jump || (is_branch && |(word.br.cond & flags));

  ////////////////////
  // Target
  ////////////////////

  // Word offsets sign extended and scaled to bytes
  assign br_disp  = {{6{word.br.offset[8]}}, word.br.offset, 1'b0};
  assign jmp_disp = {{3{word.jmp.offset[11]}}, word.jmp.offset, 1'b0};

  assign seq_pc        = id_pc + `BP_PC_BITS'd2;
  assign actual_target = seq_pc + (is_jump ? jmp_disp : br_disp);

  ////////////////////
  // Mispredict
  ////////////////////

  assign pred_taken   = predicts_taken(id_prediction);
  assign wrong_target = taken && pred_taken && (actual_target != id_target);

  always_comb begin
    resolve_valid = enable && id_valid && (is_branch || is_jump);
    resolve_taken = resolve_valid && taken;
    redirect      = resolve_valid && ((taken != pred_taken) || wrong_target);
  end

  // Taken goes to the target, not taken falls through
  assign redirect_pc = taken ? actual_target : seq_pc;

  ////////////////////
  // Table writes
  ////////////////////

  assign bht_wen      = resolve_valid;    // Counter steps on every outcome
  assign btb_wen      = resolve_taken;    // Target only learned when taken
  assign update_taken = taken;

endmodule

//--- design/branch_front_end.sv
/*
  Branch front end top level
  Fetch stage, dynamic predictor and decode-stage resolver wired together
*/

`timescale 1ns/1ps

`include "bp_config.svh"

module branch_front_end (
  input  logic        clk,
  input  logic        rst,
  input  logic        enable,          // Global stall when low
  input  logic [15:0] instr,           // From instruction memory
  input  logic [2:0]  flags,           // Condition flags for branches
  output logic [15:0] pc,              // To instruction memory
  output logic        resolve_valid,
  output logic        resolve_taken,
  output logic        mispredict
);

  import bp_state_pkg::*;

  // Fetch to predictor
  counter_t               prediction;
  logic [`BP_PC_BITS-1:0] predicted_target;

  // IF/ID to decode
  logic                   id_valid;
  logic [`BP_PC_BITS-1:0] id_pc;
  logic [`BP_PC_BITS-1:0] id_instr;
  logic [`BP_PC_BITS-1:0] id_target;
  counter_t               id_prediction;

  // Decode back to tables and fetch
  logic                   bht_wen;
  logic                   btb_wen;
  logic                   update_taken;
  logic [`BP_PC_BITS-1:0] actual_target;
  logic [`BP_PC_BITS-1:0] redirect_pc;

  branch_predictor i_branch_predictor (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .fetch_pc         (pc),
    .id_pc            (id_pc),
    .id_prediction    (id_prediction),
    .bht_wen          (bht_wen),
    .btb_wen          (btb_wen),
    .update_taken     (update_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

  fetch_unit i_fetch_unit (
    .clk              (clk),
    .rst              (rst),
    .enable           (enable),
    .instr            (instr),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .redirect         (mispredict),     // Mispredict is the redirect strobe
    .redirect_pc      (redirect_pc),
    .pc               (pc),
    .id_valid         (id_valid),
    .id_pc            (id_pc),
    .id_instr         (id_instr),
    .id_target        (id_target),
    .id_prediction    (id_prediction)
  );

  branch_resolver i_branch_resolver (
    .enable           (enable),
    .id_valid         (id_valid),
    .id_pc            (id_pc),
    .id_instr         (id_instr),
    .id_target        (id_target),
    .id_prediction    (id_prediction),
    .flags            (flags),
    .resolve_valid    (resolve_valid),
    .resolve_taken    (resolve_taken),
    .bht_wen          (bht_wen),
    .btb_wen          (btb_wen),
    .update_taken     (update_taken),
    .redirect         (mispredict),
    .actual_target    (actual_target),
    .redirect_pc      (redirect_pc)
  );

endmodule

//--- tests/tb_branch_front_end.sv
/*
  Testbench for the branch front end
  Instruction memory, reference model of PC, IF/ID and tables, directed tests
*/

`timescale 1ns/1ps

`include "bp_config.svh"

module tb_branch_front_end;

  import isa_pkg::*;

  localparam int ENTRIES   = 1 << `BP_INDEX_BITS;
  localparam int RESET_LEN = 5;         // Cycles spent in reset_dut
  localparam int TEST_LEN  = 12 + 10 + 39 + 40 + 21 + 12;
  localparam int CYCLE_LIMIT = 6 * RESET_LEN + TEST_LEN + 50;

  logic        clk;
  logic        rst;
  logic        enable;
  logic [15:0] instr;
  logic [2:0]  flags;
  logic [15:0] pc;
  logic        resolve_valid;
  logic        resolve_taken;
  logic        mispredict;

  logic [15:0] imem [256];              // Word addressed instruction memory
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          cycles;
  int          resolves;                // Counted per test from the DUT outputs
  int          misps;

  // Reference model state
  logic [15:0] m_pc;
  logic        m_id_valid;
  logic [15:0] m_id_pc;
  logic [15:0] m_id_instr;
  logic [1:0]  m_id_pred;
  logic [15:0] m_id_target;
  logic [1:0]  m_bht [ENTRIES];
  logic [15:0] m_btb [ENTRIES];

  branch_front_end i_branch_front_end (
    .clk           (clk),
    .rst           (rst),
    .enable        (enable),
    .instr         (instr),
    .flags         (flags),
    .pc            (pc),
    .resolve_valid (resolve_valid),
    .resolve_taken (resolve_taken),
    .mispredict    (mispredict)
  );

  assign instr = imem[pc[8:1]];         // Same cycle answer

  always #50 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [2:0] random_flags();
    rng_state = xorshift32(rng_state);
    return rng_state[18:16];
  endfunction

  function automatic logic [15:0] make_branch(logic [2:0] cond, int offset);
    instr_word_u w;
    w.br.opcode = op_branch;
    w.br.cond   = cond;
    w.br.offset = offset[8:0];
    return w;
  endfunction

  function automatic logic [15:0] make_jump(int offset);
    instr_word_u w;
    w.jmp.opcode = op_jump;
    w.jmp.offset = offset[11:0];
    return w;
  endfunction

  task automatic put_word(input logic [15:0] addr, input logic [15:0] word);
    imem[addr[8:1]] = word;
  endtask

  // Plain ALU words tagged with their own address
  task automatic clear_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {op_alu, 4'h0, i[7:0]};
    end
  endtask

  task automatic check_value(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic model_reset();
    m_pc        = `BP_RESET_PC;
    m_id_valid  = 1'b0;
    m_id_pc     = '0;
    m_id_instr  = '0;
    m_id_pred   = 2'b00;
    m_id_target = '0;
    for (int i = 0; i < ENTRIES; i++) begin
      m_bht[i] = 2'b00;                 // Strong not taken
      m_btb[i] = '0;
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Compare outputs with the model, then step the model over the next edge
  task automatic compare_and_advance();
    logic [15:0] w;
    logic [15:0] disp;
    logic [15:0] target;
    logic [15:0] next_pc;
    logic [15:0] fetch_target;
    logic [1:0]  fetch_pred;
    logic [1:0]  cnt;
    logic        is_br;
    logic        is_jmp;
    logic        taken;
    logic        valid;
    logic        misp;
    w      = m_id_instr;
    is_br  = (w[15:12] == op_branch);
    is_jmp = (w[15:12] == op_jump);
    disp   = is_jmp ? {{4{w[11]}}, w[11:0]} : {{7{w[8]}}, w[8:0]};
    target = m_id_pc + 16'd2 + (disp << 1);
    taken  = is_jmp || (is_br && ((w[11:9] & flags) != 3'b000));
    valid  = enable && m_id_valid && (is_br || is_jmp);
    misp   = valid && ((taken != m_id_pred[1]) || (taken && m_id_target != target));
    check_value("pc", pc, m_pc);
    check_value("resolve_valid", resolve_valid, valid);
    check_value("resolve_taken", resolve_taken, valid && taken);
    check_value("mispredict", mispredict, misp);
    if (resolve_valid) resolves++;
    if (mispredict) misps++;
    if (enable) begin
      fetch_pred   = m_bht[m_pc[`BP_INDEX_BITS:1]];   // Lookup sees the old tables
      fetch_target = m_btb[m_pc[`BP_INDEX_BITS:1]];
      if (valid) begin
        cnt = m_id_pred;
        if (taken && cnt != 2'b11) cnt = cnt + 2'b01;
        else if (!taken && cnt != 2'b00) cnt = cnt - 2'b01;
        m_bht[m_id_pc[`BP_INDEX_BITS:1]] = cnt;
        if (taken) m_btb[m_id_pc[`BP_INDEX_BITS:1]] = target;
      end
      if (misp) next_pc = taken ? target : m_id_pc + 16'd2;
      else if (fetch_pred[1]) next_pc = fetch_target;
      else next_pc = m_pc + 16'd2;
      m_id_valid  = !misp;              // Wrong-path word dropped
      m_id_pc     = m_pc;
      m_id_instr  = imem[m_pc[8:1]];
      m_id_pred   = fetch_pred;
      m_id_target = fetch_target;
      m_pc        = next_pc;
    end
  endtask

  task automatic step(input logic en, input logic [2:0] fl);
    @(posedge clk);
    enable <= en;
    flags  <= fl;
    @(negedge clk);                     // Outputs settled
    compare_and_advance();
  endtask

  task automatic reset_dut();
    @(posedge clk);
    rst    <= 1'b1;
    enable <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    model_reset();
    resolves = 0;
    misps    = 0;
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_sequential();
    clear_program();
    reset_dut();
    for (int k = 1; k <= 12; k++) begin
      step(1'b1, random_flags());
      check_value("sequential pc", pc, 16'(2 * (k - 1)));
    end
    check_value("plain word resolves", resolves, 0);
  endtask

  task automatic test_first_taken();
    clear_program();
    put_word(16'd2, make_jump(5));                 // To 14
    put_word(16'd4, make_jump(20));                // Wrong path
    put_word(16'd16, make_branch(3'b001, 3));      // To 24
    put_word(16'd18, make_jump(20));               // Wrong path
    reset_dut();
    for (int k = 1; k <= 10; k++) begin
      step(1'b1, 3'b001);
      if (k == 4) check_value("pc after jump", pc, 16'd14);
      if (k == 7) check_value("pc after branch", pc, 16'd24);
    end
    check_value("first-taken resolves", resolves, 2);
    check_value("first-taken mispredicts", misps, 2);
  endtask

  // Loop 0, 2, 4 back to 0; jump at 6 returns after a fall through
  task automatic test_hysteresis();
    clear_program();
    put_word(16'd4, make_branch(3'b010, -3));
    put_word(16'd6, make_jump(-4));
    reset_dut();
    repeat (24) step(1'b1, 3'b010);
    check_value("warm-up mispredicts", misps, 2);
    misps = 0;
    repeat (3) step(1'b1, 3'b000);
    check_value("not-taken mispredicts", misps, 1);
    misps = 0;
    repeat (12) step(1'b1, 3'b010);
    check_value("retaken mispredicts", misps, 1);   // Only the cold jump at 6
  endtask

  task automatic test_random_flags();
    clear_program();
    put_word(16'd0, make_branch(3'b001, 1));       // To 4
    put_word(16'd2, make_branch(3'b010, 2));       // To 8
    put_word(16'd4, make_branch(3'b100, -3));      // To 0
    put_word(16'd8, make_branch(3'b011, -5));      // To 0
    put_word(16'd10, make_jump(-6));               // To 0
    reset_dut();
    repeat (40) step(1'b1, random_flags());
    check_value("branches resolved", resolves != 0, 1'b1);
  endtask

  task automatic test_enable_stall();
    logic [15:0] held_pc;
    clear_program();
    put_word(16'd4, make_branch(3'b010, -3));
    put_word(16'd6, make_jump(-4));
    reset_dut();
    repeat (6) step(1'b1, random_flags());
    held_pc = m_pc;                                // PC after the last enabled edge
    for (int k = 0; k < 5; k++) begin
      step(1'b0, random_flags());
      check_value("stalled pc", pc, held_pc);
      check_value("stalled resolve_valid", resolve_valid, 1'b0);
      check_value("stalled mispredict", mispredict, 1'b0);
    end
    repeat (10) step(1'b1, random_flags());
  endtask

  // PCs 2 and 18 share index 1
  task automatic test_aliasing();
    clear_program();
    put_word(16'd2, make_branch(3'b001, 7));       // To 18
    put_word(16'd18, make_branch(3'b001, -9));     // To 2
    reset_dut();
    repeat (12) step(1'b1, 3'b001);
    check_value("aliased resolves", resolves, 5);
    check_value("aliased mispredicts", misps, 5);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    enable    = 1'b0;
    flags     = 3'b000;
    rng_state = 32'hac4f_aa14;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    clear_program();
    model_reset();
    test_sequential();
    test_first_taken();
    test_hysteresis();
    test_random_flags();
    test_enable_stall();
    test_aliasing();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+design
design/bp_state_pkg.sv
design/isa_pkg.sv
design/branch_predictor.sv
design/fetch_unit.sv
design/branch_resolver.sv
design/branch_front_end.sv
tests/tb_branch_front_end.sv
